// File: hdl/rename_cfg.svh
/*
  rename subsystem sizing
  register file counts and reorder buffer depth
*/

`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// physical register file size
`define NUM_PR 64

// architectural registers, mapped 1:1 onto the low physical regs at reset
`define NUM_AR 32

// reorder buffer slots, power of two so the pointers wrap on their own
`define NUM_ROB 8

`endif

// File: hdl/renamePkg.sv
/*
  register identity types
  physical and architectural register numbers
*/

`default_nettype none

`include "rename_cfg.svh"

package renamePkg;

  // physical register number, 6 bits for 64 regs
  typedef logic [$clog2(`NUM_PR)-1:0] physReg;

  // architectural register number, 5 bits for 32 regs
  typedef logic [$clog2(`NUM_AR)-1:0] archReg;

endpackage

`default_nettype wire

// File: hdl/robPkg.sv
/*
  reorder buffer types
  slot index and packed entry layout, 18 bits per entry
*/

`default_nettype none

`include "rename_cfg.svh"

package robPkg;
  import renamePkg::*;

  typedef logic [$clog2(`NUM_ROB)-1:0] robIdx;

  // one slot, valid on top
  typedef struct packed {
    logic   valid;
    physReg newPhys;
    physReg oldPhys;
    archReg archDest;
  } robEntry;

endpackage

`default_nettype wire

// File: hdl/mapTable.sv
/*
  speculative map table
  architectural to physical mapping, identity after reset
  one combinational read and one write per dispatch
*/

`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module mapTable import renamePkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   dispatchTake,
  input  archReg archDest,
  input  physReg physDest,
  output physReg oldPhys
);

  // one physical reg per architectural reg
  physReg mapEntry [`NUM_AR];

  // current mapping of the destination
  // this is the reg freed once the instruction retires
  assign oldPhys = mapEntry[archDest];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, arch i lives in phys i
      for (int i = 0; i < `NUM_AR; i++) begin
        mapEntry[i] <= physReg'(i);
      end
    end else if (dispatchTake) begin
      // new mapping takes over right away
      // so a back-to-back dispatch to the same reg sees this one as old
      mapEntry[archDest] <= physDest;
    end
  end

endmodule

`default_nettype wire

// File: hdl/freeList.sv
/*
  free list of physical registers
  circular queue, popped at dispatch and pushed at retire
  starts out holding the regs above the architectural range
*/

`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module freeList import renamePkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   pop,
  input  logic   push,
  input  physReg pushReg,
  output physReg headReg,
  output logic   empty
);

  // only NUM_PR - NUM_AR regs are ever free at once
  localparam int depth = `NUM_PR - `NUM_AR;
  localparam int ptrWidth = $clog2(depth);
  localparam int cntWidth = $clog2(depth + 1);
  localparam logic [ptrWidth-1:0] lastSlot = ptrWidth'(depth - 1);

  physReg slots [depth];
  logic [ptrWidth-1:0] head;
  logic [ptrWidth-1:0] tail;
  logic [cntWidth-1:0] count;
  logic [ptrWidth-1:0] nextHead;
  logic [ptrWidth-1:0] nextTail;

  // pointer wrap, explicit so depth need not be a power of two
  assign nextHead = (head == lastSlot) ? '0 : head + 1'b1;
  assign nextTail = (tail == lastSlot) ? '0 : tail + 1'b1;

  // oldest free reg goes out first
  assign headReg = slots[head];
  assign empty   = (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      // upper regs, ascending
      for (int i = 0; i < depth; i++) begin
        slots[i] <= physReg'(`NUM_AR + i);
      end
      head  <= '0;
      // queue starts full, tail wrapped back onto head
      tail  <= '0;
      count <= cntWidth'(depth);
    end else begin
      if (pop) begin
        head <= nextHead;
      end
      if (push) begin
        slots[tail] <= pushReg;
        tail        <= nextTail;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/reorderBuffer.sv
/*
  reorder buffer
  circular array of entries with head and tail pointers
  writes at the tail on dispatch, frees the head on retire
*/

`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module reorderBuffer import renamePkg::*, robPkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   write,
  input  physReg newPhys,
  input  physReg oldPhys,
  input  archReg archDest,
  input  logic   free,
  output logic   full,
  output robIdx  tailIdx,
  output robIdx  headIdx,
  output logic   headValid,
  output physReg headOld
);

  robEntry entries [`NUM_ROB];
  robIdx   head;
  robIdx   tail;
  robIdx   nextHead;
  robIdx   nextTail;
  robEntry tailEntry;

  // depth is a power of two, pointers wrap naturally
  always_comb begin
    nextHead = free  ? head + robIdx'(1) : head;
    nextTail = write ? tail + robIdx'(1) : tail;
  end

  // entry built from the dispatch inputs
  always_comb begin
    tailEntry.valid    = 1'b1;
    tailEntry.newPhys  = newPhys;
    tailEntry.oldPhys  = oldPhys;
    tailEntry.archDest = archDest;
  end

  // tail slot still occupied means no room left
  // valid bit alone tells full from empty when head == tail
  assign full = entries[tail].valid;

  // slot a dispatch would take this cycle
  assign tailIdx = tail;

  // oldest instruction, seen by retire
  assign headIdx   = head;
  assign headValid = entries[head].valid;
  assign headOld   = entries[head].oldPhys;

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      // valid bits only, payload is don't care until written
      for (int i = 0; i < `NUM_ROB; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else begin
      head <= nextHead;
      tail <= nextTail;
      // retire drops the oldest slot
      if (free) begin
        entries[head].valid <= 1'b0;
      end
      // dispatch fills the tail slot
      // write needs an invalid tail and free a valid head, never the same slot
      if (write) begin
        entries[tail] <= tailEntry;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/renameUnit.sv
/*
  register rename unit
  map table, free list and reorder buffer with shared dispatch and retire
  stall is a plain level from the buffer and the free list
*/

`timescale 1ns/1ps
`default_nettype none

module renameUnit import renamePkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         enable,
  input  logic         dispatch,
  input  archReg       archDest,
  input  logic         retire,
  output logic         stall,
  output physReg       physDest,
  output physReg       oldPhys,
  output robPkg::robIdx robIdx,
  output robPkg::robIdx headIdx,
  output logic         retireValid,
  output physReg       retireOld
);

  logic robFull;
  logic listEmpty;
  logic dispatchTake;
  logic retireTake;

  // no look-ahead, a same-cycle retire does not lift a full stall
  assign stall = robFull | listEmpty;

  // qualified strobes, shared by all three blocks
  assign dispatchTake = enable & dispatch & ~stall;
  assign retireTake   = enable & retire & retireValid;

  mapTable mapTable_inst (
    .clock        (clock),
    .reset        (reset),
    .dispatchTake (dispatchTake),
    .archDest     (archDest),
    .physDest     (physDest),
    .oldPhys      (oldPhys)
  );

  // retired old regs flow back to the tail of the queue
  freeList freeList_inst (
    .clock   (clock),
    .reset   (reset),
    .pop     (dispatchTake),
    .push    (retireTake),
    .pushReg (retireOld),
    .headReg (physDest),
    .empty   (listEmpty)
  );

  reorderBuffer reorderBuffer_inst (
    .clock     (clock),
    .reset     (reset),
    .write     (dispatchTake),
    .newPhys   (physDest),
    .oldPhys   (oldPhys),
    .archDest  (archDest),
    .free      (retireTake),
    .full      (robFull),
    .tailIdx   (robIdx),
    .headIdx   (headIdx),
    .headValid (retireValid),
    .headOld   (retireOld)
  );

endmodule

`default_nettype wire

// File: bench/renameUnitChecker.sv
/*
  rename unit checker
  concurrent assertions on stall, free list occupancy and reset state
*/

`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module renameUnitChecker (
  input logic clock,
  input logic reset,
  input logic [$clog2(`NUM_ROB)-1:0] tailIdx,
  input logic [$clog2(`NUM_ROB)-1:0] headIdx,
  input logic stall,
  input logic retireValid,
  input logic [$clog2(`NUM_PR - `NUM_AR + 1)-1:0] listCount
);

  // pointers meeting on a valid head means the buffer is full
  // and a full buffer must always hold off dispatch
  stallWhenFull: assert property (
    @(posedge clock) disable iff (reset) (tailIdx == headIdx) && retireValid |-> stall
  ) else $error("stall low while the reorder buffer is full");

  // only retired old regs come back so the pool never grows
  countBound: assert property (
    @(posedge clock) disable iff (reset) listCount <= (`NUM_PR - `NUM_AR)
  ) else $error("free list holds more regs than the initial pool");

  // valid bits cleared by the reset edge
  emptyAfterReset: assert property (
    @(posedge clock) reset |=> !retireValid
  ) else $error("retireValid high in the cycle after reset");

endmodule

bind renameUnit renameUnitChecker renameUnitChecker_inst (
  .clock       (clock),
  .reset       (reset),
  .tailIdx     (robIdx),
  .headIdx     (headIdx),
  .stall       (stall),
  .retireValid (retireValid),
  .listCount   (freeList_inst.count)
);

`default_nettype wire

// File: bench/renameUnitTb.sv
/*
  rename unit testbench
  directed and random dispatch/retire traffic against a reference model
*/

`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module renameUnitTb import renamePkg::*;;

  localparam int initialFree = `NUM_PR - `NUM_AR;
  localparam int waitLimit = 20;

  logic clock;
  logic reset;
  logic enable;
  logic dispatch;
  archReg archDest;
  logic retire;
  logic stall;
  physReg physDest;
  physReg oldPhys;
  logic [$clog2(`NUM_ROB)-1:0] robIdx;
  logic [$clog2(`NUM_ROB)-1:0] headIdx;
  logic retireValid;
  physReg retireOld;

  // reference model state
  physReg modelMap [`NUM_AR];
  physReg modelFree [$];
  physReg modelRobOld [`NUM_ROB];
  int modelHead;
  int modelTail;
  int modelCount;

  // old regs in retire order and dispatches since reset
  physReg returned [$];
  int popCount;
  int errors;
  int checkCount;
  int testCount;
  int startErrors;
  bit timedOut;

  renameUnit renameUnit_inst (
    .clock       (clock),
    .reset       (reset),
    .enable      (enable),
    .dispatch    (dispatch),
    .archDest    (archDest),
    .retire      (retire),
    .stall       (stall),
    .physDest    (physDest),
    .oldPhys     (oldPhys),
    .robIdx      (robIdx),
    .headIdx     (headIdx),
    .retireValid (retireValid),
    .retireOld   (retireOld)
  );

  always #4 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // identity map with upper regs free and an empty buffer
  function automatic void resetModel();
    modelFree.delete();
    for (int i = 0; i < `NUM_AR; i++) begin
      modelMap[i] = physReg'(i);
    end
    for (int i = 0; i < initialFree; i++) begin
      modelFree.push_back(physReg'(`NUM_AR + i));
    end
    modelHead = 0;
    modelTail = 0;
    modelCount = 0;
  endfunction

  function automatic bit expectStall();
    return (modelCount == `NUM_ROB) || (modelFree.size() == 0);
  endfunction

  // state the DUT should reach on the next edge
  function automatic void stepModel(input bit en, input bit disp, input archReg ad,
                                    input bit ret);
    bit takeDispatch;
    bit takeRetire;
    physReg headOld;
    takeDispatch = en && disp && !expectStall();
    takeRetire = en && ret && (modelCount > 0);
    headOld = modelRobOld[modelHead];
    if (takeDispatch) begin
      modelRobOld[modelTail] = modelMap[ad];
      modelMap[ad] = modelFree.pop_front();
      modelTail = (modelTail + 1) % `NUM_ROB;
      modelCount++;
    end
    if (takeRetire) begin
      modelFree.push_back(headOld);
      modelHead = (modelHead + 1) % `NUM_ROB;
      modelCount--;
    end
  endfunction

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] want);
    checkCount++;
    assert (got === want) else begin
      errors++;
      $display("ERROR %0t ns: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clock) begin
    if (reset) begin
      resetModel();
    end else begin
      checkValue("stall", stall, expectStall());
      if (modelFree.size() > 0) begin
        checkValue("physDest", physDest, modelFree[0]);
      end
      checkValue("oldPhys", oldPhys, modelMap[archDest]);
      checkValue("robIdx", robIdx, modelTail);
      checkValue("headIdx", headIdx, modelHead);
      checkValue("retireValid", retireValid, modelCount > 0);
      if (modelCount > 0) begin
        checkValue("retireOld", retireOld, modelRobOld[modelHead]);
      end
      stepModel(enable, dispatch, archDest, retire);
    end
  end

  task automatic reportHang(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, waitLimit);
    timedOut = 1'b1;
    forever @(posedge clock);
  endtask

  // hold one dispatch until it is taken
  task automatic dispatchOne(input archReg ad, output physReg p, output physReg o,
                             output logic [$clog2(`NUM_ROB)-1:0] idx);
    int waited;
    waited = 0;
    @(posedge clock);
    dispatch <= 1'b1;
    archDest <= ad;
    @(negedge clock);
    while (stall) begin
      waited++;
      if (waited > waitLimit) begin
        reportHang("dispatch past stall");
      end
      @(negedge clock);
    end
    p = physDest;
    o = oldPhys;
    idx = robIdx;
    // regs come back in retire order once the initial pool is used
    if (popCount >= initialFree && returned.size() > 0) begin
      checkValue("reused physDest", p, returned.pop_front());
    end
    popCount++;
    @(posedge clock);
    dispatch <= 1'b0;
  endtask

  task automatic retireOne();
    int waited;
    waited = 0;
    @(posedge clock);
    retire <= 1'b1;
    @(negedge clock);
    while (!retireValid) begin
      waited++;
      if (waited > waitLimit) begin
        reportHang("retire of a valid head");
      end
      @(negedge clock);
    end
    returned.push_back(retireOld);
    @(posedge clock);
    retire <= 1'b0;
  endtask

  task automatic endTest(input string name);
    $display("test %-10s %s, %0d errors", name,
             (errors == startErrors) ? "ok" : "mismatch", errors - startErrors);
    testCount++;
    startErrors = errors;
  endtask

  initial begin
    wait (timedOut);
    $display("stopped by timeout after %0d checks, %0d errors", checkCount, errors);
    $display("sim failed");
    $finish;
  end

  initial begin
    physReg p;
    physReg o;
    physReg p1;
    logic [$clog2(`NUM_ROB)-1:0] idx;
    logic [$clog2(`NUM_ROB)-1:0] savedIdx;
    logic [$clog2(`NUM_ROB)-1:0] savedHead;
    physReg savedPhys;
    logic [31:0] rng;
    reset = 1'b1;
    clock = 1'b0;
    enable = 1'b1;
    dispatch = 1'b0;
    retire = 1'b0;
    archDest = '0;
    rng = 32'hf62d40c9;
    repeat (5) @(posedge clock);
    reset <= 1'b0;

    // identity map then the first dispatch
    for (int i = 0; i < `NUM_AR; i++) begin
      @(posedge clock);
      archDest <= archReg'(i);
      @(negedge clock);
      checkValue("oldPhys after reset", oldPhys, i);
    end
    checkValue("headIdx after reset", headIdx, 0);
    checkValue("retireValid after reset", retireValid, 0);
    dispatchOne(5'd7, p, o, idx);
    checkValue("first physDest", p, `NUM_AR);
    checkValue("first robIdx", idx, 0);
    endTest("reset");

    // same arch reg twice
    dispatchOne(5'd12, p1, o, idx);
    dispatchOne(5'd12, p, o, idx);
    checkValue("chained oldPhys", o, p1);
    checkValue("ascending physDest", p, p1 + 1);
    endTest("chain");

    // empty the buffer and walk the tail round to slot 0
    repeat (3) retireOne();
    repeat (5) begin
      dispatchOne(5'd1, p, o, idx);
      retireOne();
    end
    @(negedge clock);
    checkValue("tail realigned", robIdx, 0);
    for (int i = 0; i < `NUM_ROB; i++) begin
      dispatchOne(archReg'(i), p, o, idx);
    end
    @(negedge clock);
    checkValue("stall when full", stall, 1);
    // ninth dispatch waits until a retire frees a slot
    fork
      dispatchOne(5'd9, p, o, idx);
      begin
        repeat (3) @(posedge clock);
        retireOne();
      end
    join
    checkValue("wrapped robIdx", idx, 0);
    endTest("full");

    // buffer stays full so retire goes first
    for (int i = 0; i < 40; i++) begin
      retireOne();
      dispatchOne(archReg'(i), p, o, idx);
    end
    endTest("reuse");

    retireOne();
    @(posedge clock);
    enable <= 1'b0;
    dispatch <= 1'b1;
    retire <= 1'b1;
    archDest <= 5'd3;
    @(negedge clock);
    savedIdx = robIdx;
    savedHead = headIdx;
    savedPhys = physDest;
    repeat (4) begin
      @(negedge clock);
      checkValue("robIdx frozen", robIdx, savedIdx);
      checkValue("headIdx frozen", headIdx, savedHead);
      checkValue("physDest frozen", physDest, savedPhys);
    end
    @(posedge clock);
    enable <= 1'b1;
    dispatch <= 1'b0;
    retire <= 1'b0;
    endTest("enable");

    // random strobes with enable mostly high
    for (int i = 0; i < 2000; i++) begin
      @(posedge clock);
      rng = xorshift(rng);
      enable <= (rng[3:0] != 4'h0);
      dispatch <= rng[4];
      retire <= rng[5];
      archDest <= rng[12:8];
    end
    @(posedge clock);
    dispatch <= 1'b0;
    retire <= 1'b0;
    repeat (2) @(negedge clock);
    endTest("random");

    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/renamePkg.sv
hdl/robPkg.sv
hdl/mapTable.sv
hdl/freeList.sv
hdl/reorderBuffer.sv
hdl/renameUnit.sv
bench/renameUnitChecker.sv
bench/renameUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the rename unit testbench with Verilator and run it
# exit status is nonzero when the build, the run or the checks fail

set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module renameUnitTb -o renameUnitSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "verilator build returned status $buildStatus"
  exit 1
fi

./obj_dir/renameUnitSim > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
  echo "simulation returned status $runStatus"
  exit 1
fi

if grep -q "sim failed" "$logFile"; then
  exit 1
fi

exit 0
